// ==== src/fetch_settings.svh ====
// Memory depth must be a power of two and the reset PC must be halfword aligned

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

////////////////////
// Address space
////////////////////

// Byte address width of the fetch side
`define FETCH_AW 32

// PC loaded on reset
`define FETCH_RESET_PC 32'h0000_0000

////////////////////
// Program memory
////////////////////

// Depth in 32-bit words
`define FETCH_MEM_WORDS 64

// Word index width, follows the depth
`define FETCH_IDX_W $clog2(`FETCH_MEM_WORDS)

`endif

// ==== src/fetch_pkg.sv ====
// Shared fetch types; parcel order is little endian, low halfword first in memory

`include "fetch_settings.svh"

package fetch_pkg;

  ////////////////////
  // Instruction word
  ////////////////////

  // Two 16-bit parcels of one fetched word
  typedef struct packed {
    logic [15:0] hi;                      // Parcel at byte offset 2
    logic [15:0] lo;                      // Parcel at byte offset 0
  } parcel_pair_s;

  // One fetched word, seen whole or as two compressed parcels
  typedef union packed {
    logic [31:0]  word;                   // Full 32-bit instruction
    parcel_pair_s half;                   // Compressed halves
  } instr_word_u;

  // How the current instruction sits in its word
  typedef enum logic [1:0] {
    FMT_FULL_ALIGNED   = 2'd0,            // 32-bit at word boundary
    FMT_C_ALIGNED      = 2'd1,            // 16-bit in the low half
    FMT_C_MISALIGNED   = 2'd2             // 16-bit in the high half
  } instr_fmt_e;

  ////////////////////
  // Bundles
  ////////////////////

  // Decode-side issue bundle, 66 bits
  typedef struct packed {
    logic [`FETCH_AW-1:0] addr;           // Instruction byte address
    logic [31:0]          instr;          // Upper half zero when compressed
    logic                 compressed;     // Low two bits not 2'b11
    logic                 illegal;        // Full instruction at misaligned PC
  } issue_s;

  // Loader write bundle, 38 bits
  typedef struct packed {
    logic [`FETCH_IDX_W-1:0] idx;         // Word index into program memory
    logic [31:0]             data;        // Word to write
  } load_s;

endpackage

// ==== src/prefetch_aligned.sv ====
// Needs read data exactly one cycle after grant; a full instruction across two words is flagged illegal

`timescale 1ns/1ps

`include "fetch_settings.svh"

module prefetch_aligned (
  input  logic                   clk,
  input  logic                   rst_n,

  // Core side control
  input  logic                   req_i,          // Fetch enable
  input  logic                   branch_i,       // Redirect strobe
  input  logic [`FETCH_AW-1:0]   branch_addr_i,  // Redirect target

  // Toward issue stage
  input  logic                   ready_i,
  output logic                   valid_o,
  output fetch_pkg::instr_word_u instr_o,
  output logic [`FETCH_AW-1:0]   addr_o,
  output logic                   illegal_o,

  // Toward instruction memory
  output logic                   mem_req_o,
  input  logic                   mem_gnt_i,
  output logic [`FETCH_AW-1:0]   mem_addr_o,     // Always word aligned
  input  fetch_pkg::instr_word_u mem_rdata_i,
  input  logic                   mem_rvalid_i
);

  ////////////////////
  // Declarations
  ////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,                                     // No access in flight
    ST_WAIT_GNT,                                 // Request up, no grant yet
    ST_WAIT_RVALID                               // Granted, data due
  } state_e;

  state_e                 state_q, state_d;
  logic [`FETCH_AW-1:0]   fetch_addr_q, fetch_addr_d;  // The PC
  fetch_pkg::instr_word_u rdata_q;               // Last word read
  logic                   held_q, held_d;        // rdata_q still serves fetch_addr_q

  fetch_pkg::instr_word_u word_mux;              // Word the PC points into
  logic [15:0]            parcel;                // Halfword at the PC
  fetch_pkg::instr_fmt_e  fmt;
  logic [2:0]             pc_step;               // 2 or 4
  logic [`FETCH_AW-1:0]   pc_next;
  logic [`FETCH_AW-1:0]   req_addr;              // Byte address for this cycle's request
  logic                   word_avail;            // An instruction can be presented
  logic                   take;                  // Transfer to issue stage

  ////////////////////
  // Datapath
  ////////////////////

  // Fresh memory data while waiting, else the held word
  assign word_mux = (state_q == ST_WAIT_RVALID) ? mem_rdata_i : rdata_q;
  assign parcel   = fetch_addr_q[1] ? word_mux.half.hi : word_mux.half.lo;

  // Classify by PC alignment and the low parcel's quadrant bits
  always_comb begin
    if (fetch_addr_q[1]) begin
      fmt = fetch_pkg::FMT_C_MISALIGNED;         // Only compressed is legal up here
    end else if (word_mux.half.lo[1:0] != 2'b11) begin
      fmt = fetch_pkg::FMT_C_ALIGNED;
    end else begin
      fmt = fetch_pkg::FMT_FULL_ALIGNED;
    end
  end

  // Single PC adder for all formats
  assign pc_step = (fmt == fetch_pkg::FMT_FULL_ALIGNED) ? 3'd4 : 3'd2;
  assign pc_next = fetch_addr_q + {{(`FETCH_AW-3){1'b0}}, pc_step};

  // Aligned word passed whole, a high parcel moves down zero extended
  always_comb begin
    if (fmt == fetch_pkg::FMT_C_MISALIGNED) begin
      instr_o.word = {16'h0000, parcel};
    end else begin
      instr_o.word = word_mux.word;
    end
  end

  // Misaligned full instruction is issued once with the flag
  assign illegal_o = (fmt == fetch_pkg::FMT_C_MISALIGNED) && (parcel[1:0] == 2'b11);
  assign addr_o    = fetch_addr_q;

  // Held word only while enabled; memory data whenever it lands
  assign word_avail = (state_q == ST_IDLE && held_q && req_i) ||
                      (state_q == ST_WAIT_RVALID && mem_rvalid_i);
  assign valid_o    = word_avail && !branch_i;   // Branch kills the presented word
  assign take       = valid_o && ready_i;

  assign mem_addr_o = {req_addr[`FETCH_AW-1:2], 2'b00};

  ////////////////////
  // Fetch FSM
  ////////////////////

  always_comb begin
    state_d      = state_q;
    fetch_addr_d = fetch_addr_q;
    held_d       = held_q;
    mem_req_o    = 1'b0;
    req_addr     = fetch_addr_q;

    if (branch_i) begin
      // Drop held word and any data landing now, restart at target
      fetch_addr_d = branch_addr_i;
      held_d       = 1'b0;
      req_addr     = branch_addr_i;
      if (req_i) begin
        mem_req_o = 1'b1;
        state_d   = mem_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
      end else begin
        state_d   = ST_IDLE;
      end
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (req_i && !held_q) begin            // Nothing buffered, go to memory
            mem_req_o = 1'b1;
            state_d   = mem_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
          end
        end
        ST_WAIT_GNT: begin
          mem_req_o = 1'b1;                      // Keep asking
          if (mem_gnt_i) begin
            state_d = ST_WAIT_RVALID;
          end
        end
        ST_WAIT_RVALID: begin
          if (mem_rvalid_i) begin                // Word captured; stall keeps it
            held_d  = 1'b1;
            state_d = ST_IDLE;
          end
        end
        default: state_d = ST_IDLE;
      endcase

      // Instruction accepted, advance PC
      if (take) begin
        fetch_addr_d = pc_next;
        req_addr     = pc_next;
        if (fmt == fetch_pkg::FMT_C_ALIGNED) begin
          // Upper parcel comes from the held word, no access
          held_d  = 1'b1;
          state_d = ST_IDLE;
        end else begin
          held_d = 1'b0;                         // PC moved to next word
          if (req_i) begin
            mem_req_o = 1'b1;
            state_d   = mem_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
          end else begin
            state_d   = ST_IDLE;
          end
        end
      end
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      fetch_addr_q <= `FETCH_RESET_PC;
      held_q       <= 1'b0;
    end else begin
      state_q      <= state_d;
      fetch_addr_q <= fetch_addr_d;
      held_q       <= held_d;
    end
  end

  // Payload word, overwritten on every arrival
  always_ff @(posedge clk) begin
    if (state_q == ST_WAIT_RVALID && mem_rvalid_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

endmodule

// ==== src/instr_mem.sv ====
// Word-addressed RAM; address bits above the depth wrap, contents undefined until loaded

`timescale 1ns/1ps

`include "fetch_settings.svh"

module instr_mem (
  input  logic                   clk,
  input  logic                   rst_n,

  // Fetch read port
  input  logic                   req_i,
  output logic                   gnt_o,
  input  logic [`FETCH_AW-1:0]   addr_i,      // Byte address, low bits ignored
  output fetch_pkg::instr_word_u rdata_o,
  output logic                   rvalid_o,
  input  logic                   stall_i,     // Wait state injection

  // Loader write port, four-phase
  input  logic                   load_req_i,
  input  fetch_pkg::load_s       load_i,
  output logic                   load_ack_o
);

  ////////////////////
  // Storage
  ////////////////////

  logic [31:0]             mem_q [`FETCH_MEM_WORDS];
  logic [`FETCH_IDX_W-1:0] rd_idx;
  fetch_pkg::instr_word_u  rdata_q;
  logic                    rvalid_q;
  logic                    ack_q;
  logic                    load_wr;            // Rising edge of ack

  assign rd_idx = addr_i[`FETCH_IDX_W+1:2];

  ////////////////////
  // Read port
  ////////////////////

  // Grant in the same cycle unless stalled
  assign gnt_o = req_i && !stall_i;

  // One rvalid per grant, one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_o) begin
      rdata_q.word <= mem_q[rd_idx];
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

  ////////////////////
  // Loader port
  ////////////////////

  // Ack follows req by one cycle in both directions
  assign load_wr = load_req_i && !ack_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= load_req_i;
    end
  end

  // Write lands on the edge where ack rises
  always_ff @(posedge clk) begin
    if (load_wr) begin
      mem_q[load_i.idx] <= load_i.data;
    end
  end

  assign load_ack_o = ack_q;

endmodule

// ==== src/issue_stage.sv ====
// Single-entry ready/valid register; flush drops the entry and ignores input that cycle

`timescale 1ns/1ps

`include "fetch_settings.svh"

module issue_stage (
  input  logic                   clk,
  input  logic                   rst_n,

  // From prefetch buffer
  input  logic                   valid_i,
  output logic                   ready_o,
  input  fetch_pkg::instr_word_u instr_i,
  input  logic [`FETCH_AW-1:0]   addr_i,
  input  logic                   illegal_i,
  input  logic                   flush_i,     // Branch taken

  // Toward decode
  output fetch_pkg::issue_s      issue_o,
  output logic                   valid_o,
  input  logic                   ready_i
);

  ////////////////////
  // Classify
  ////////////////////

  fetch_pkg::issue_s issue_d;
  fetch_pkg::issue_s issue_q;                 // Payload, no reset
  logic              valid_q;
  logic              is_compressed;
  logic              load_en;

  // Quadrant bits of the opcode field
  assign is_compressed = (instr_i.half.lo[1:0] != 2'b11);

  always_comb begin
    issue_d.addr       = addr_i;
    issue_d.instr      = is_compressed ? {16'h0000, instr_i.half.lo} : instr_i.word;
    issue_d.compressed = is_compressed;
    issue_d.illegal    = illegal_i;
  end

  ////////////////////
  // Handshake
  ////////////////////

  // Free slot, or the slot empties this cycle
  assign ready_o = !valid_q || ready_i;
  assign load_en = valid_i && ready_o && !flush_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;                        // Old path dropped
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      issue_q <= issue_d;
    end
  end

  assign issue_o = issue_q;
  assign valid_o = valid_q;

endmodule

// ==== src/fetch_top.sv ====
// Fetch front end; branch must be a single-cycle strobe and loading should finish before fetch_en

`timescale 1ns/1ps

`include "fetch_settings.svh"

module fetch_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Control
  input  logic                 fetch_en_i,
  input  logic                 branch_i,
  input  logic [`FETCH_AW-1:0] branch_addr_i,
  input  logic                 mem_stall_i,   // Memory wait states

  // Loader
  input  logic                 load_req_i,
  input  fetch_pkg::load_s     load_i,
  output logic                 load_ack_o,

  // Decode side
  output fetch_pkg::issue_s    issue_o,
  output logic                 issue_valid_o,
  input  logic                 issue_ready_i
);

  ////////////////////
  // Interconnect
  ////////////////////

  // Prefetch to memory
  logic                   mem_req;
  logic                   mem_gnt;
  logic [`FETCH_AW-1:0]   mem_addr;
  fetch_pkg::instr_word_u mem_rdata;
  logic                   mem_rvalid;

  // Prefetch to issue stage
  logic                   pf_valid;
  logic                   pf_ready;
  fetch_pkg::instr_word_u pf_instr;
  logic [`FETCH_AW-1:0]   pf_addr;
  logic                   pf_illegal;

  prefetch_aligned u_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (fetch_en_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .ready_i       (pf_ready),
    .valid_o       (pf_valid),
    .instr_o       (pf_instr),
    .addr_o        (pf_addr),
    .illegal_o     (pf_illegal),
    .mem_req_o     (mem_req),
    .mem_gnt_i     (mem_gnt),
    .mem_addr_o    (mem_addr),
    .mem_rdata_i   (mem_rdata),
    .mem_rvalid_i  (mem_rvalid)
  );

  instr_mem u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (mem_req),
    .gnt_o      (mem_gnt),
    .addr_i     (mem_addr),
    .rdata_o    (mem_rdata),
    .rvalid_o   (mem_rvalid),
    .stall_i    (mem_stall_i),
    .load_req_i (load_req_i),
    .load_i     (load_i),
    .load_ack_o (load_ack_o)
  );

  // Branch also clears the issue register
  issue_stage u_issue (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_i   (pf_valid),
    .ready_o   (pf_ready),
    .instr_i   (pf_instr),
    .addr_i    (pf_addr),
    .illegal_i (pf_illegal),
    .flush_i   (branch_i),
    .issue_o   (issue_o),
    .valid_o   (issue_valid_o),
    .ready_i   (issue_ready_i)
  );

endmodule

// ==== testbench/fetch_tb_table.svh ====
// Included inside fetch_tb only; the image head is fixed and the fill assumes a 64-word memory

`ifndef FETCH_TB_TABLE_SVH
`define FETCH_TB_TABLE_SVH

////////////////////
// Program image
////////////////////

localparam int HEAD_WORDS = 12;

// Words 0-3 full, 4-7 compressed pairs, 8-11 targets for misaligned branches
logic [31:0] head_words [0:HEAD_WORDS-1] = '{
  32'h0010_0093, 32'h0020_8113, 32'h0031_0193, 32'h0041_8213,
  32'h4505_4485, 32'h0505_0485, 32'h8082_4501, 32'h4681_4601,
  32'h4585_0001, 32'h0050_0313, 32'h0393_4605, 32'h0070_0413
};

// Odd words full, even words a compressed pair, both built from the index
function automatic logic [31:0] image_word(input int idx);
  logic [7:0] i;
  i = idx[7:0];
  if (idx < HEAD_WORDS) begin
    return head_words[idx];
  end else if (idx[0]) begin
    return {4'h0, i, 20'h0_0093};               // addi with index immediate
  end else begin
    return {i, 8'h05, ~i, 8'h85};               // Both parcels quadrant 01
  end
endfunction

////////////////////
// Step table
////////////////////

// Columns: name, branch, target, expected first address, instructions, random pressure
typedef struct packed {
  logic [8*12-1:0] name;
  logic            branch;
  logic [31:0]     target;
  logic [31:0]     first;
  logic [7:0]      count;
  logic            rand_mode;                   // Random stalls and ready
} step_s;

localparam int NUM_STEPS = 7;

step_s step_tbl [0:NUM_STEPS-1] = '{
  '{"seq_full",   1'b0, 32'h00, 32'h00, 8'd4,  1'b0},
  '{"c_pairs",    1'b0, 32'h00, 32'h10, 8'd8,  1'b0},
  '{"mis_c",      1'b1, 32'h22, 32'h22, 8'd2,  1'b0},
  '{"mis_full",   1'b1, 32'h2a, 32'h2a, 8'd2,  1'b0},
  '{"rand_press", 1'b1, 32'h10, 32'h10, 8'd40, 1'b1},
  '{"br_pending", 1'b1, 32'h40, 32'h40, 8'd6,  1'b0},
  '{"br_back",    1'b1, 32'h04, 32'h04, 8'd5,  1'b0}
};

`endif

// ==== testbench/fetch_tb.sv ====
// Model walks the loaded image from the PC; steps must stay below the memory wrap

`timescale 1ns/1ps

`include "fetch_settings.svh"

module fetch_tb;

  logic                 clk;
  logic                 rst_n;
  logic                 fetch_en_i;
  logic                 branch_i;
  logic [`FETCH_AW-1:0] branch_addr_i;
  logic                 mem_stall_i;
  logic                 load_req_i;
  fetch_pkg::load_s     load_i;
  logic                 load_ack_o;
  fetch_pkg::issue_s    issue_o;
  logic                 issue_valid_o;
  logic                 issue_ready_i;

  `include "fetch_tb_table.svh"

  logic [31:0] image [0:`FETCH_MEM_WORDS-1];    // Copy of the loaded words
  logic [15:0] lfsr;
  logic [31:0] model_pc;
  int          value_errs;
  int          proto_errs;

  fetch_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                     // 100 ns period
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Four-phase write of one word
  task automatic load_word(input int idx, input logic [31:0] data);
    @(negedge clk);
    if (load_ack_o !== 1'b0) begin
      proto_errs++;
      $display("Loader ack already high before request for word %0d", idx);
    end
    load_req_i  = 1'b1;
    load_i.idx  = idx[`FETCH_IDX_W-1:0];
    load_i.data = data;
    @(negedge clk);
    if (load_ack_o !== 1'b1) begin
      proto_errs++;
      $display("Loader ack did not rise one cycle after request for word %0d", idx);
    end
    while (load_ack_o !== 1'b1) @(negedge clk);
    load_req_i = 1'b0;                          // Return to zero
    @(negedge clk);
    if (load_ack_o !== 1'b0) begin
      proto_errs++;
      $display("Loader ack did not fall one cycle after release for word %0d", idx);
    end
    while (load_ack_o !== 1'b0) @(negedge clk);
  endtask

  // One LFSR bit each for stall and ready
  task automatic drive_pressure(input logic rand_mode);
    if (rand_mode) begin
      lfsr          = lfsr_step(lfsr);
      mem_stall_i   = lfsr[0];
      lfsr          = lfsr_step(lfsr);
      issue_ready_i = lfsr[0];
    end else begin
      mem_stall_i   = 1'b0;
      issue_ready_i = 1'b1;
    end
  endtask

  // Next expected issue from the image, advances the model PC
  task automatic model_next(inout logic [31:0] pc, output fetch_pkg::issue_s exp);
    logic [31:0] word;
    logic [15:0] parcel;
    word       = image[pc[`FETCH_IDX_W+1:2]];
    parcel     = pc[1] ? word[31:16] : word[15:0];
    exp.addr   = pc;
    exp.instr  = {16'h0000, parcel};
    exp.illegal = 1'b0;
    if (parcel[1:0] != 2'b11) begin
      exp.compressed = 1'b1;                    // Quadrant 00, 01 or 10
      pc             = pc + 32'd2;
    end else if (pc[1]) begin
      exp.compressed = 1'b0;                    // Full word split across words
      exp.illegal    = 1'b1;
      pc             = pc + 32'd2;
    end else begin
      exp.compressed = 1'b0;
      exp.instr      = word;
      pc             = pc + 32'd4;
    end
  endtask

  task automatic check_transfer(input step_s st, input int nth);
    fetch_pkg::issue_s exp;
    model_next(model_pc, exp);
    if (nth == 0 && issue_o.addr !== st.first) begin
      value_errs++;
      $display("FAILED %0s first address: expected %h, actual %h",
               st.name, st.first, issue_o.addr);
    end
    if (issue_o !== exp) begin
      value_errs++;
      $display("FAILED %0s #%0d: expected %h %h c%b i%b, actual %h %h c%b i%b", st.name, nth,
               exp.addr, exp.instr, exp.compressed, exp.illegal,
               issue_o.addr, issue_o.instr, issue_o.compressed, issue_o.illegal);
    end
  endtask

  // Optional branch, then collect the step's transfers
  task automatic run_step(input step_s st);
    int got;
    got = 0;
    if (st.branch) begin
      @(negedge clk);
      branch_i      = 1'b1;
      branch_addr_i = st.target;
      issue_ready_i = 1'b0;                     // No decode transfer in the branch cycle
      mem_stall_i   = 1'b0;
      model_pc      = st.target;
      @(negedge clk);
      branch_i = 1'b0;
      if (issue_valid_o !== 1'b0) begin
        proto_errs++;
        $display("Issue valid still high after branch in step %0s", st.name);
      end
    end
    while (got < st.count) begin
      @(negedge clk);
      drive_pressure(st.rand_mode);
      if (issue_valid_o === 1'b1 && issue_ready_i === 1'b1) begin
        check_transfer(st, got);                // Transfer lands on the next rising edge
        got++;
      end
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_n         = 1'b0;
    fetch_en_i    = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    mem_stall_i   = 1'b0;
    load_req_i    = 1'b0;
    load_i        = '0;
    issue_ready_i = 1'b0;
    lfsr          = 16'd38837;
    model_pc      = `FETCH_RESET_PC;
    value_errs    = 0;
    proto_errs    = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (load_ack_o !== 1'b0 || issue_valid_o !== 1'b0) begin
      proto_errs++;
      $display("Loader ack or issue valid not low after reset");
    end
    for (int i = 0; i < `FETCH_MEM_WORDS; i++) begin
      image[i] = image_word(i);
      load_word(i, image[i]);
    end
    @(negedge clk);
    fetch_en_i = 1'b1;                          // Start at the reset PC
    for (int s = 0; s < NUM_STEPS; s++) begin
      run_step(step_tbl[s]);
    end
    @(negedge clk);
    issue_ready_i = 1'b0;
    fetch_en_i    = 1'b0;
    $display("Errors: %0d value, %0d handshake", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    int limit;
    @(posedge rst_n);
    limit = `FETCH_MEM_WORDS * 8 + 50;          // Load time with margin
    for (int s = 0; s < NUM_STEPS; s++) begin
      limit += 200 * (step_tbl[s].count + 1);
    end
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, loader or fetch made no progress", limit);
    $display("Errors: %0d value, %0d handshake", value_errs, proto_errs);
    $display("test failed");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+src
+incdir+testbench
src/fetch_pkg.sv
src/prefetch_aligned.sv
src/instr_mem.sv
src/issue_stage.sv
src/fetch_top.sv
testbench/fetch_tb.sv
